//--- logic/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// data word and byte address width
`define WORD_W 32

// register specifier width, rs / rt / rd fields
`define REG_AW 5

// architectural general purpose registers
`define NUM_REGS 32

`endif

//--- logic/isaPkg.sv
package isaPkg;

	// primary opcode, instr[31:26]
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,
		OP_J       = 6'h02,
		OP_BEQ     = 6'h04,
		OP_ADDIU   = 6'h09,
		OP_LW      = 6'h23,
		OP_SW      = 6'h2B
	} opcodeT;

	// funct field of SPECIAL, instr[5:0]
	typedef enum logic [5:0] {
		FN_JR   = 6'h08,
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_SLT  = 6'h2A
	} functT;

	// internal alu operation, carried down to execute
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT
	} aluOpT;

endpackage

//--- logic/pipePkg.sv
package pipePkg;

	// operand source for the decode and execute forwarding muxes
	typedef enum logic [1:0] {
		FWD_REGFILE = 2'd0,
		FWD_MEM     = 2'd1,
		FWD_WB      = 2'd2
	} fwdSelT;

	// what lands in the register file at writeback
	typedef enum logic {
		WB_ALU = 1'b0,
		WB_MEM = 1'b1
	} wbSrcT;

endpackage

//--- logic/regFile.sv
`timescale 1ns/10ps
`include "cpu_defs.svh"

module regFile (
	input  logic               clk,
	input  logic               arstN,
	input  logic               we,
	input  logic [`REG_AW-1:0] ra1,
	input  logic [`REG_AW-1:0] ra2,
	input  logic [`REG_AW-1:0] wa,
	input  logic [`WORD_W-1:0] wd,
	output logic [`WORD_W-1:0] rd1,
	output logic [`WORD_W-1:0] rd2
);
	logic [`WORD_W-1:0] regs [`NUM_REGS];

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wa != '0) begin
			regs[wa] <= wd;
		end
	end

	// r0 hardwired, then same-cycle write passes straight through
	assign rd1 = (ra1 == '0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];
	assign rd2 = (ra2 == '0) ? '0 : (we && wa == ra2) ? wd : regs[ra2];

endmodule

//--- logic/alu.sv
`timescale 1ns/10ps
`include "cpu_defs.svh"

module alu (
	input  logic [`WORD_W-1:0] a,
	input  logic [`WORD_W-1:0] b,
	input  isaPkg::aluOpT      aluOp,
	output logic [`WORD_W-1:0] y
);
	import isaPkg::*;

	logic lessThan;

	// two's complement compare for slt
	assign lessThan = $signed(a) < $signed(b);

	always_comb begin
		case (aluOp)
			ALU_ADD: y = a + b;
			ALU_SUB: y = a - b;
			ALU_AND: y = a & b;
			ALU_OR:  y = a | b;
			// result is 0 or 1
			ALU_SLT: y = {{(`WORD_W-1){1'b0}}, lessThan};
			default: y = a + b;
		endcase
	end

endmodule

//--- logic/controlUnit.sv
`timescale 1ns/10ps
`include "cpu_defs.svh"

module controlUnit (
	input  logic [`WORD_W-1:0] instrD,
	output logic               regWriteD,
	output logic               memWriteD,
	output pipePkg::wbSrcT     wbSrcD,
	output logic               aluSrcD,
	output logic               regDstD,
	output logic               branchD,
	output logic               jumpD,
	output logic               jumpRegD,
	output isaPkg::aluOpT      aluOpD
);
	import isaPkg::*;
	import pipePkg::*;

	opcodeT opD;
	functT  functD;

	assign opD    = opcodeT'(instrD[31:26]);
	assign functD = functT'(instrD[5:0]);

	always_comb begin
		// defaults describe a no-op, nothing written anywhere
		regWriteD = 1'b0;
		memWriteD = 1'b0;
		wbSrcD    = WB_ALU;
		aluSrcD   = 1'b0;
		regDstD   = 1'b0;
		branchD   = 1'b0;
		jumpD     = 1'b0;
		jumpRegD  = 1'b0;
		aluOpD    = ALU_ADD;
		case (opD)
			OP_SPECIAL: begin
				// r-type, destination in rd
				regDstD = 1'b1;
				case (functD)
					FN_ADDU: regWriteD = 1'b1;
					FN_SUBU: begin
						regWriteD = 1'b1;
						aluOpD    = ALU_SUB;
					end
					FN_AND: begin
						regWriteD = 1'b1;
						aluOpD    = ALU_AND;
					end
					FN_OR: begin
						regWriteD = 1'b1;
						aluOpD    = ALU_OR;
					end
					FN_SLT: begin
						regWriteD = 1'b1;
						aluOpD    = ALU_SLT;
					end
					FN_JR:   jumpRegD = 1'b1;
					default: regDstD = 1'b0;
				endcase
			end
			OP_ADDIU: begin
				regWriteD = 1'b1;
				aluSrcD   = 1'b1;
			end
			OP_LW: begin
				// address = rs + simm, result from memory into rt
				regWriteD = 1'b1;
				aluSrcD   = 1'b1;
				wbSrcD    = WB_MEM;
			end
			OP_SW: begin
				memWriteD = 1'b1;
				aluSrcD   = 1'b1;
			end
			OP_BEQ:  branchD = 1'b1;
			OP_J:    jumpD = 1'b1;
			default: regWriteD = 1'b0;
		endcase
	end

endmodule

//--- logic/hazardUnit.sv
`timescale 1ns/10ps
`include "cpu_defs.svh"

module hazardUnit (
	input  logic [`REG_AW-1:0] rsD, rtD, rsE, rtE,
	input  logic [`REG_AW-1:0] writeRegE, writeRegM, writeRegW,
	input  logic               regWriteE, regWriteM, regWriteW,
	input  pipePkg::wbSrcT     wbSrcE, wbSrcM,
	input  logic               branchD,
	input  logic               jumpRegD,
	input  logic               iStall,
	input  logic               dStall,
	output logic               stallF, stallD, flushE, stallE, stallM, stallW,
	output pipePkg::fwdSelT    fwdAD, fwdBD, fwdAE, fwdBE,
	output logic               longestStall
);
	import pipePkg::*;

	logic lwStall;
	logic rsBusyD;
	logic rtBusyD;
	logic branchStall;
	logic internalStall;

	// memory stage wins over writeback, it holds the younger value
	// r0 writes never show up here, the datapath drops them in execute
	function automatic fwdSelT pickFwd(input logic [`REG_AW-1:0] src);
		if (regWriteM && writeRegM == src) begin
			return FWD_MEM;
		end
		if (regWriteW && writeRegW == src) begin
			return FWD_WB;
		end
		return FWD_REGFILE;
	endfunction

	////////////////////////////////////////
	// forwarding
	always_comb begin
		fwdAD = pickFwd(rsD);
		fwdBD = pickFwd(rtD);
		fwdAE = pickFwd(rsE);
		fwdBE = pickFwd(rtE);
	end

	////////////////////////////////////////
	// interlocks
	// load in execute feeding the instruction in decode
	assign lwStall = regWriteE && wbSrcE == WB_MEM && (writeRegE == rsD || writeRegE == rtD);

	// compare in decode needs the value now
	// alu result still in execute, or load data still in memory stage
	assign rsBusyD = (regWriteE && writeRegE == rsD)
		|| (regWriteM && wbSrcM == WB_MEM && writeRegM == rsD);
	assign rtBusyD = (regWriteE && writeRegE == rtD)
		|| (regWriteM && wbSrcM == WB_MEM && writeRegM == rtD);
	assign branchStall = (branchD && (rsBusyD || rtBusyD)) || (jumpRegD && rsBusyD);

	assign internalStall = lwStall | branchStall;

	////////////////////////////////////////
	// stall distribution
	assign longestStall = iStall | dStall;

	// external stall freezes every bank, no bubble while frozen
	assign stallF = internalStall | longestStall;
	assign stallD = internalStall | longestStall;
	assign flushE = internalStall & ~longestStall;
	assign stallE = longestStall;
	assign stallM = longestStall;
	assign stallW = longestStall;

endmodule

//--- logic/datapath.sv
`timescale 1ns/10ps
`include "cpu_defs.svh"

module datapath (
	input  logic               clk,
	input  logic               arstN,
	// instruction side
	output logic [`WORD_W-1:0] pcF,
	input  logic [`WORD_W-1:0] instrF,
	// data side
	output logic               memWriteM,
	output logic [3:0]         byteEnM,
	output logic [`WORD_W-1:0] aluOutM,
	output logic [`WORD_W-1:0] writeDataM,
	input  logic [`WORD_W-1:0] readDataM,
	input  logic               longestStall,
	// debug writeback
	output logic [`WORD_W-1:0] debugWbPc,
	output logic [3:0]         debugWbRfWen,
	output logic [`REG_AW-1:0] debugWbRfWnum,
	output logic [`WORD_W-1:0] debugWbRfWdata,
	// decode to and from control
	output logic [`WORD_W-1:0] instrD,
	input  logic               regWriteD, memWriteD, aluSrcD, regDstD,
	input  logic               branchD, jumpD, jumpRegD,
	input  pipePkg::wbSrcT     wbSrcD,
	input  isaPkg::aluOpT      aluOpD,
	// hazard controls
	input  logic               stallF, stallD, flushE, stallE, stallM, stallW,
	input  pipePkg::fwdSelT    fwdAD, fwdBD, fwdAE, fwdBE,
	// seen by the hazard unit
	output logic [`REG_AW-1:0] rsD, rtD, rsE, rtE,
	output logic [`REG_AW-1:0] writeRegE, writeRegM, writeRegW,
	output logic               regWriteE, regWriteM, regWriteW,
	output pipePkg::wbSrcT     wbSrcE, wbSrcM
);
	import isaPkg::*;
	import pipePkg::*;

	localparam logic [`WORD_W-1:0] RESET_PC = 32'hBFC0_0000;

	// fetch
	logic [`WORD_W-1:0] pcPlus4F, pcNextF;
	// decode
	logic [`WORD_W-1:0] pcD, pcPlus4D, rd1D, rd2D, srcAD, srcBD, immD;
	logic [`WORD_W-1:0] branchTargetD, jumpTargetD;
	logic [`REG_AW-1:0] rdD;
	logic               equalD;
	// execute
	logic               regWriteRawE, memWriteE, aluSrcE, regDstE;
	aluOpT              aluOpE;
	logic [`WORD_W-1:0] pcE, rd1E, rd2E, immE, srcAE, srcBE, aluBE, aluOutE;
	logic [`REG_AW-1:0] rdE;
	// memory
	logic               memWriteRawM;
	logic [`WORD_W-1:0] pcM;
	// writeback
	wbSrcT              wbSrcW;
	logic [`WORD_W-1:0] pcW, aluOutW, readDataW, resultW;

	function automatic logic [`WORD_W-1:0] fwdMux(
		input fwdSelT             sel,
		input logic [`WORD_W-1:0] rfVal,
		input logic [`WORD_W-1:0] memVal,
		input logic [`WORD_W-1:0] wbVal
	);
		case (sel)
			FWD_MEM: return memVal;
			FWD_WB:  return wbVal;
			default: return rfVal;
		endcase
	endfunction

	////////////////////////////////////////
	// fetch
	assign pcPlus4F = pcF + 32'd4;

	// redirect happens in decode, the slot already in fetch still runs
	assign pcNextF = jumpRegD ? srcAD
		: jumpD ? jumpTargetD
		: (branchD && equalD) ? branchTargetD
		: pcPlus4F;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			pcF <= RESET_PC;
		end else if (!stallF) begin
			pcF <= pcNextF;
		end
	end

	// F/D bank, all-zero word decodes as a no-op
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			instrD <= '0;
		end else if (!stallD) begin
			instrD <= instrF;
		end
	end

	always_ff @(posedge clk) begin
		if (!stallD) begin
			pcD <= pcF;
		end
	end

	////////////////////////////////////////
	// decode
	assign rsD  = instrD[25:21];
	assign rtD  = instrD[20:16];
	assign rdD  = instrD[15:11];
	assign immD = {{16{instrD[15]}}, instrD[15:0]};

	// targets relative to the delay slot
	assign pcPlus4D      = pcD + 32'd4;
	assign branchTargetD = pcPlus4D + {immD[`WORD_W-3:0], 2'b00};
	assign jumpTargetD   = {pcPlus4D[31:28], instrD[25:0], 2'b00};

	regFile uRegFile (
		.clk   (clk),
		.arstN (arstN),
		.we    (regWriteW),
		.ra1   (rsD),
		.ra2   (rtD),
		.wa    (writeRegW),
		.wd    (resultW),
		.rd1   (rd1D),
		.rd2   (rd2D)
	);

	// beq compare and jr target see forwarded operands
	assign srcAD  = fwdMux(fwdAD, rd1D, aluOutM, resultW);
	assign srcBD  = fwdMux(fwdBD, rd2D, aluOutM, resultW);
	assign equalD = srcAD == srcBD;

	// D/E bank, flush turns it into a bubble
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			regWriteRawE <= 1'b0;
			memWriteE    <= 1'b0;
			wbSrcE       <= WB_ALU;
		end else if (!stallE) begin
			regWriteRawE <= regWriteD & ~flushE;
			memWriteE    <= memWriteD & ~flushE;
			wbSrcE       <= flushE ? WB_ALU : wbSrcD;
		end
	end

	always_ff @(posedge clk) begin
		if (!stallE) begin
			aluSrcE <= aluSrcD;
			regDstE <= regDstD;
			aluOpE  <= aluOpD;
			pcE     <= pcD;
			rd1E    <= rd1D;
			rd2E    <= rd2D;
			immE    <= immD;
			rsE     <= rsD;
			rtE     <= rtD;
			rdE     <= rdD;
		end
	end

	////////////////////////////////////////
	// execute
	assign writeRegE = regDstE ? rdE : rtE;
	// r0 target drops the write here, so later stages never see it
	assign regWriteE = regWriteRawE && writeRegE != '0;

	assign srcAE = fwdMux(fwdAE, rd1E, aluOutM, resultW);
	assign srcBE = fwdMux(fwdBE, rd2E, aluOutM, resultW);
	assign aluBE = aluSrcE ? immE : srcBE;

	alu uAlu (
		.a     (srcAE),
		.b     (aluBE),
		.aluOp (aluOpE),
		.y     (aluOutE)
	);

	// E/M bank
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			regWriteM    <= 1'b0;
			memWriteRawM <= 1'b0;
			wbSrcM       <= WB_ALU;
		end else if (!stallM) begin
			regWriteM    <= regWriteE;
			memWriteRawM <= memWriteE;
			wbSrcM       <= wbSrcE;
		end
	end

	always_ff @(posedge clk) begin
		if (!stallM) begin
			aluOutM    <= aluOutE;
			writeDataM <= srcBE;
			writeRegM  <= writeRegE;
			pcM        <= pcE;
		end
	end

	////////////////////////////////////////
	// memory
	// strobe held back while frozen, so a store commits once
	assign memWriteM = memWriteRawM & ~longestStall;
	// word stores only
	assign byteEnM = 4'b1111;

	// M/W bank
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			regWriteW <= 1'b0;
			wbSrcW    <= WB_ALU;
		end else if (!stallW) begin
			regWriteW <= regWriteM;
			wbSrcW    <= wbSrcM;
		end
	end

	always_ff @(posedge clk) begin
		if (!stallW) begin
			aluOutW   <= aluOutM;
			readDataW <= readDataM;
			writeRegW <= writeRegM;
			pcW       <= pcM;
		end
	end

	////////////////////////////////////////
	// writeback
	assign resultW = (wbSrcW == WB_MEM) ? readDataW : aluOutW;

	// reported on the one unfrozen cycle the write sits in W
	assign debugWbPc      = pcW;
	assign debugWbRfWen   = {4{regWriteW & ~longestStall}};
	assign debugWbRfWnum  = writeRegW;
	assign debugWbRfWdata = resultW;

endmodule

//--- logic/mipsCore.sv
`timescale 1ns/10ps
`include "cpu_defs.svh"

module mipsCore (
	input  logic               clk,
	input  logic               arstN,
	output logic [`WORD_W-1:0] pcF,
	input  logic [`WORD_W-1:0] instrF,
	output logic               memWriteM,
	output logic [3:0]         byteEnM,
	output logic [`WORD_W-1:0] aluOutM,
	output logic [`WORD_W-1:0] writeDataM,
	input  logic [`WORD_W-1:0] readDataM,
	input  logic               iStall,
	input  logic               dStall,
	output logic               longestStall,
	output logic [`WORD_W-1:0] debugWbPc,
	output logic [3:0]         debugWbRfWen,
	output logic [`REG_AW-1:0] debugWbRfWnum,
	output logic [`WORD_W-1:0] debugWbRfWdata
);
	import isaPkg::*;
	import pipePkg::*;

	// decode controls
	logic [`WORD_W-1:0] instrD;
	logic               regWriteD, memWriteD, aluSrcD, regDstD;
	logic               branchD, jumpD, jumpRegD;
	wbSrcT              wbSrcD;
	aluOpT              aluOpD;

	// hazard unit in both directions
	logic               stallF, stallD, flushE, stallE, stallM, stallW;
	fwdSelT             fwdAD, fwdBD, fwdAE, fwdBE;
	logic [`REG_AW-1:0] rsD, rtD, rsE, rtE;
	logic [`REG_AW-1:0] writeRegE, writeRegM, writeRegW;
	logic               regWriteE, regWriteM, regWriteW;
	wbSrcT              wbSrcE, wbSrcM;

	// names line up across all three blocks
	datapath uDatapath (.*);

	controlUnit uControl (.*);

	hazardUnit uHazard (.*);

endmodule

//--- dv/mipsCore_sva.sv
`timescale 1ns/10ps
`include "cpu_defs.svh"

module mipsCore_sva (
	input logic               clk,
	input logic               arstN,
	input logic               longestStall,
	input logic               memWriteM,
	input logic [`WORD_W-1:0] pcF,
	input logic [3:0]         debugWbRfWen
);

	// frozen fetch keeps its address
	pcHoldA: assert property (@(posedge clk) disable iff (!arstN)
		longestStall |=> $stable(pcF))
		else $error("pcF moved across an external stall");

	// no register write reported while frozen
	wbQuietA: assert property (@(posedge clk) disable iff (!arstN)
		longestStall |-> debugWbRfWen == 4'h0)
		else $error("debug write enable active during stall");

	// bubbles in memory stage through reset and the cycle after
	resetStoreA: assert property (@(posedge clk)
		!arstN |-> !memWriteM)
		else $error("store strobe during reset");

	releaseStoreA: assert property (@(posedge clk)
		$rose(arstN) |-> !memWriteM)
		else $error("store strobe in first cycle after reset");

endmodule

bind mipsCore mipsCore_sva uSva (.*);

//--- dv/mipsCore_tb.sv
`timescale 1ns/10ps
`include "cpu_defs.svh"

module mipsCore_tb;

	logic               clk;
	logic               arstN;
	logic [`WORD_W-1:0] pcF, instrF;
	logic               memWriteM;
	logic [3:0]         byteEnM;
	logic [`WORD_W-1:0] aluOutM, writeDataM, readDataM;
	logic               iStall, dStall, longestStall;
	logic [`WORD_W-1:0] debugWbPc;
	logic [3:0]         debugWbRfWen;
	logic [`REG_AW-1:0] debugWbRfWnum;
	logic [`WORD_W-1:0] debugWbRfWdata;

	// memories, indexed by word
	logic [`WORD_W-1:0] imem [256];
	logic [`WORD_W-1:0] dmem [256];
	logic [`WORD_W-1:0] dinit [256];

	// expected writeback records and final memory words
	logic [`WORD_W-1:0] expPc[$];
	logic [`WORD_W-1:0] expReg[$];
	logic [`WORD_W-1:0] expVal[$];
	logic [`WORD_W-1:0] memIdx[$];
	logic [`WORD_W-1:0] memWord[$];
	int                 expStores;
	int                 numExp;
	bit                 loaded;

	int recIdx;
	int storeCount;
	int errCount;
	int testsRun;
	int testsFailed;
	bit stallOn;

	mipsCore dut_i (.*);

	always #20 clk = ~clk;

	// instruction and load data come back in the same cycle
	assign instrF    = imem[pcF[9:2]];
	assign readDataM = dmem[aluOutM[9:2]];

	////////////////////////////////////////
	// stimulus file
	task automatic loadStim();
		int                 fd;
		int                 n;
		string              line;
		logic [7:0]         tag;
		logic [`WORD_W-1:0] a, b, c;
		fd = $fopen("dv/prog_stim.txt", "r");
		if (fd == 0) begin
			$display("cannot open stimulus file dv/prog_stim.txt");
		end else begin
			for (int i = 0; i < 256; i++) begin
				imem[i]  = '0;
				dinit[i] = '0;
			end
			expStores = 0;
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if (n > 1 && line.getc(0) != "#") begin
					n = $sscanf(line, "%c %h %h %h", tag, a, b, c);
					case (tag)
						"P": imem[a[7:0]] = b;
						"D": dinit[a[7:0]] = b;
						"M": begin
							memIdx.push_back(a);
							memWord.push_back(b);
						end
						"E": begin
							expPc.push_back(a);
							expReg.push_back(b);
							expVal.push_back(c);
						end
						"S": expStores = int'(a);
						default: ;
					endcase
				end
			end
			$fclose(fd);
			numExp = expPc.size();
			loaded = 1'b1;
		end
	endtask

	task automatic checkWord(string name, logic [`WORD_W-1:0] got, logic [`WORD_W-1:0] exp);
		assert (got === exp) else begin
			$display("MISMATCH t=%0t %s expected %h got %h", $time, name, exp, got);
			errCount++;
		end
	endtask

	////////////////////////////////////////
	// data memory, reloaded while in reset
	always @(posedge clk) begin
		if (!arstN) begin
			for (int i = 0; i < 256; i++) begin
				dmem[i] <= dinit[i];
			end
			storeCount <= 0;
		end else if (memWriteM) begin
			// word stores only
			checkWord("byteEnM", {28'b0, byteEnM}, 32'hF);
			dmem[aluOutM[9:2]] <= writeDataM;
			storeCount <= storeCount + 1;
		end
	end

	// writeback trace, compared in program order
	always @(posedge clk) begin
		if (!arstN) begin
			recIdx <= 0;
		end else begin
			// freeze follows either stall input
			checkWord("longestStall", {31'b0, longestStall}, {31'b0, iStall | dStall});
			if (recIdx == 0) begin
				checkWord("memWriteM", {31'b0, memWriteM}, '0);
			end
			if (debugWbRfWen != 4'h0) begin
				assert (recIdx < numExp) else begin
					$display("t=%0t unexpected extra writeback from pc %h", $time, debugWbPc);
					errCount++;
				end
				if (recIdx < numExp) begin
					checkWord("debugWbRfWen", {28'b0, debugWbRfWen}, 32'hF);
					checkWord("debugWbPc", debugWbPc, expPc[recIdx]);
					checkWord("debugWbRfWnum", {27'b0, debugWbRfWnum}, expReg[recIdx]);
					checkWord("debugWbRfWdata", debugWbRfWdata, expVal[recIdx]);
				end
				recIdx <= recIdx + 1;
			end
		end
	end

	// random freeze windows on both sides
	always @(negedge clk) begin
		if (stallOn) begin
			iStall = ($urandom % 4) == 0;
			dStall = ($urandom % 4) == 0;
		end else begin
			iStall = 1'b0;
			dStall = 1'b0;
		end
	end

	task automatic report(string name, int errBefore);
		testsRun++;
		if (errCount == errBefore) begin
			$display("%s: PASS", name);
		end else begin
			testsFailed++;
			$display("%s: FAIL", name);
		end
	endtask

	task automatic runPass(string mode);
		int e;
		@(negedge clk);
		arstN = 1'b0;
		repeat (5) @(negedge clk);
		arstN = 1'b1;
		e = errCount;
		checkWord("pcF", pcF, 32'hBFC0_0000);
		checkWord("memWriteM", {31'b0, memWriteM}, '0);
		checkWord("debugWbRfWen", {28'b0, debugWbRfWen}, '0);
		report({"reset ", mode}, e);
		e = errCount;
		wait (recIdx == numExp && storeCount == expStores);
		// drain, catches repeats and late stores
		repeat (20) @(negedge clk);
		report({"trace ", mode}, e);
		e = errCount;
		foreach (memIdx[i]) begin
			checkWord($sformatf("dmem[%0d]", memIdx[i]), dmem[memIdx[i][7:0]], memWord[i]);
		end
		report({"memory ", mode}, e);
		e = errCount;
		checkWord("storeCount", storeCount, expStores);
		report({"stores ", mode}, e);
	endtask

	////////////////////////////////////////
	// main sequence
	initial begin
		clk = 1'b0;
		arstN = 1'b0;
		iStall = 1'b0;
		dStall = 1'b0;
		stallOn = 1'b0;
		errCount = 0;
		testsRun = 0;
		testsFailed = 0;
		loaded = 1'b0;
		void'($urandom(71));
		loadStim();
		if (loaded) begin
			runPass("stall-free");
			stallOn = 1'b1;
			runPass("random stalls");
		end else begin
			errCount++;
		end
		$display("%0d tests run, %0d failed, %0d check errors", testsRun, testsFailed, errCount);
		if (errCount == 0 && testsFailed == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	// two passes, 40 cycles per record plus reset slack
	initial begin
		wait (loaded);
		#(2 * (numExp * 40 + 40) * 40);
		$display("watchdog expired before all writebacks were seen");
		$display("Test failures found");
		$finish;
	end

endmodule

//--- dv/prog_stim.txt
# P word-index instr | D word-index data | E pc reg value (writeback order)
# M word-index expected final data | S number of stores
P 00 24010005
P 01 24020003
P 02 00221821
P 03 00612023
P 04 00642824
P 05 00643025
P 06 0083382A
P 07 24080040
P 08 AD060000
P 09 8D090000
P 0A 01215021
P 0B 24000007
P 0C 00015821
P 0D 10220002
P 0E 240C0001
P 0F 11260002
P 10 240D0002
P 11 240E0063
P 12 0BF00015
P 13 240F0004
P 14 2410004D
P 15 8C110004
P 16 02200008
P 17 24120006
P 18 24130037
P 19 0220A021
P 1A AC140008
P 1B 0BF0001B
P 1C 00000000
D 01 BFC00064
E BFC00000 01 00000005
E BFC00004 02 00000003
E BFC00008 03 00000008
E BFC0000C 04 00000003
E BFC00010 05 00000000
E BFC00014 06 0000000B
E BFC00018 07 00000001
E BFC0001C 08 00000040
E BFC00024 09 0000000B
E BFC00028 0A 00000010
E BFC00030 0B 00000005
E BFC00038 0C 00000001
E BFC00040 0D 00000002
E BFC0004C 0F 00000004
E BFC00054 11 BFC00064
E BFC0005C 12 00000006
E BFC00064 14 BFC00064
M 10 0000000B
M 01 BFC00064
M 02 BFC00064
M 00 00000000
S 2

//--- verilog.f
+incdir+logic
logic/isaPkg.sv
logic/pipePkg.sv
logic/regFile.sv
logic/alu.sv
logic/controlUnit.sv
logic/hazardUnit.sv
logic/datapath.sv
logic/mipsCore.sv
dv/mipsCore_sva.sv
dv/mipsCore_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f verilog.f --top-module mipsCore_tb
output=$(./obj_dir/VmipsCore_tb)
echo "$output"
if echo "$output" | grep -qF "All tests passed!"; then
	exit 0
else
	exit 1
fi
